// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    // instruction beat, ready is advance at the top level
    input  logic               instr_valid,
    input  isa_pkg::instr_u    instr,
    input  logic               advance,
    // write-back from the result register
    input  logic               wb_en,
    input  isa_pkg::reg_addr_t wb_rd,
    input  isa_pkg::word_t     wb_data,
    // decoded operation toward the execute register
    output logic               ex_valid,
    output pipe_pkg::alu_op_e  ex_op,
    output logic               ex_use_imm,
    output isa_pkg::word_t     ex_imm,
    output isa_pkg::reg_addr_t ex_rs1,
    output isa_pkg::reg_addr_t ex_rs2,
    output isa_pkg::word_t     ex_rs1_data,
    output isa_pkg::word_t     ex_rs2_data,
    output isa_pkg::reg_addr_t ex_rd
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic    d_valid;       // decode register holds a live instruction
    instr_u  d_instr;       // accepted instruction word
    alu_op_e base_op;       // funct3 map of the base integer group
    logic    base_ok;       // funct3 is one of the kept base ops
    logic    legal;         // whole instruction is inside the subset
    word_t   rf_rs1_data;   // raw reads, before write-back forwarding
    word_t   rf_rs2_data;

    // ============================================================
    // decode register
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
            d_instr <= '0;
        end else if (advance) begin     // advance doubles as instr_ready
            d_valid <= instr_valid;     // no beat -> bubble moves in
            d_instr <= instr;
        end
    end

    // ============================================================
    // field decoding
    // ============================================================
    // funct3 sits in the same bits in both views
    always_comb begin
        base_op = alu_add;
        base_ok = 1'b1;
        case (d_instr.r_fmt.funct3)
            f3_add:  base_op = alu_add;
            f3_slt:  base_op = alu_slt;
            f3_sltu: base_op = alu_sltu;
            f3_xor:  base_op = alu_xor;
            f3_or:   base_op = alu_or;
            f3_and:  base_op = alu_and;
            default: base_ok = 1'b0;    // shifts are not kept
        endcase
    end

    always_comb begin
        ex_op      = base_op;
        ex_use_imm = 1'b0;
        legal      = 1'b1;
        case (d_instr.r_fmt.opcode)
            op_reg: begin
                if (d_instr.r_fmt.funct7 == f7_muldiv) begin
                    case (d_instr.r_fmt.funct3)
                        f3_mul:    ex_op = alu_mul;
                        f3_mulh:   ex_op = alu_mulh;
                        f3_mulhsu: ex_op = alu_mulhsu;
                        f3_mulhu:  ex_op = alu_mulhu;
                        default:   legal = 1'b0;    // div and rem
                    endcase
                end else if (d_instr.r_fmt.funct7 == f7_sub) begin
                    ex_op = alu_sub;
                    legal = (d_instr.r_fmt.funct3 == f3_add);   // sra is not kept
                end else begin
                    legal = (d_instr.r_fmt.funct7 == f7_base) && base_ok;
                end
            end
            op_imm: begin
                ex_use_imm = 1'b1;      // operand b comes from the i view
                legal      = base_ok;
            end
            default: legal = 1'b0;
        endcase
        // outside the subset: add 0 + 0, still retires with its rd
        if (!legal) begin
            ex_op      = alu_add;
            ex_use_imm = 1'b1;
        end
    end

    assign ex_valid = d_valid;
    assign ex_rd    = d_instr.r_fmt.rd;
    assign ex_imm   = legal ? {{(xlen-12){d_instr.i_fmt.imm[11]}}, d_instr.i_fmt.imm} : '0;
    assign ex_rs1   = legal ? d_instr.r_fmt.rs1 : '0;     // x0 reads zero
    assign ex_rs2   = (legal && !ex_use_imm) ? d_instr.r_fmt.rs2 : '0;  // i-type has no rs2

    // ============================================================
    // register reads with write-back forwarding
    // ============================================================
    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (ex_rs1),
        .rs2      (ex_rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .we       (wb_en),
        .wd_addr  (wb_rd),
        .wd_data  (wb_data)
    );

    // wb_en already excludes x0, so a zero index never matches
    assign ex_rs1_data = (wb_en && (wb_rd == ex_rs1)) ? wb_data : rf_rs1_data;
    assign ex_rs2_data = (wb_en && (wb_rd == ex_rs2)) ? wb_data : rf_rs2_data;

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    // decoded operation from decode
    input  logic               ex_valid,
    input  pipe_pkg::alu_op_e  ex_op,
    input  logic               ex_use_imm,
    input  isa_pkg::word_t     ex_imm,
    input  isa_pkg::reg_addr_t ex_rs1,
    input  isa_pkg::reg_addr_t ex_rs2,
    input  isa_pkg::word_t     ex_rs1_data,
    input  isa_pkg::word_t     ex_rs2_data,
    input  isa_pkg::reg_addr_t ex_rd,
    // result register contents, one stage ahead
    input  logic               fwd_en,
    input  isa_pkg::reg_addr_t fwd_rd,
    input  isa_pkg::word_t     fwd_data,
    // toward the result register
    output logic               alu_valid,
    output isa_pkg::reg_addr_t alu_rd,
    output isa_pkg::word_t     alu_result
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // execute register
    logic      e_valid;
    alu_op_e   e_op;
    logic      e_use_imm;
    word_t     e_imm;
    reg_addr_t e_rs1;
    reg_addr_t e_rs2;
    word_t     e_rs1_data;
    word_t     e_rs2_data;
    reg_addr_t e_rd;

    word_t op_a;                            // rs1 after forwarding
    word_t rs2_val;                         // rs2 after forwarding
    word_t op_b;                            // rs2 or immediate
    logic signed [2*xlen-1:0] prod_ss;      // signed x signed
    logic        [2*xlen-1:0] prod_uu;      // unsigned x unsigned, also low word
    logic signed [2*xlen+1:0] prod_su;      // 33-bit operands, signed x unsigned

    // ============================================================
    // execute register
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid    <= 1'b0;
            e_op       <= alu_add;
            e_use_imm  <= 1'b0;
            e_imm      <= '0;
            e_rs1      <= '0;
            e_rs2      <= '0;
            e_rs1_data <= '0;
            e_rs2_data <= '0;
            e_rd       <= '0;
        end else if (advance) begin
            e_valid    <= ex_valid;
            e_op       <= ex_op;
            e_use_imm  <= ex_use_imm;
            e_imm      <= ex_imm;
            e_rs1      <= ex_rs1;
            e_rs2      <= ex_rs2;
            e_rs1_data <= ex_rs1_data;
            e_rs2_data <= ex_rs2_data;
            e_rd       <= ex_rd;
        end
    end

    // ============================================================
    // result-to-execute forwarding and operand select
    // ============================================================
    // the older instruction in the result register wins over the captured read
    assign op_a    = (fwd_en && (fwd_rd == e_rs1)) ? fwd_data : e_rs1_data;
    assign rs2_val = (fwd_en && (fwd_rd == e_rs2)) ? fwd_data : e_rs2_data;
    assign op_b    = e_use_imm ? e_imm : rs2_val;

    // ============================================================
    // alu
    // ============================================================
    assign prod_ss = $signed(op_a) * $signed(op_b);
    assign prod_uu = op_a * op_b;
    assign prod_su = $signed({op_a[xlen-1], op_a}) * $signed({1'b0, op_b});

    always_comb begin
        case (e_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_mul:    alu_result = prod_uu[xlen-1:0];     // low word is sign-agnostic
            alu_mulh:   alu_result = prod_ss[2*xlen-1:xlen];
            alu_mulhsu: alu_result = prod_su[2*xlen-1:xlen];
            alu_mulhu:  alu_result = prod_uu[2*xlen-1:xlen];
            default:    alu_result = '0;
        endcase
    end

    assign alu_valid = e_valid;
    assign alu_rd    = e_rd;

endmodule

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int xlen = 32;               // data word width

    typedef logic [4:0]      reg_addr_t;    // x0..x31
    typedef logic [xlen-1:0] word_t;

    // ============================================================
    // opcodes and function fields of the kept subset
    // ============================================================
    localparam logic [6:0] op_reg = 7'b0110011;     // register-register
    localparam logic [6:0] op_imm = 7'b0010011;     // register-immediate

    // base integer group, shared by both formats
    localparam logic [2:0] f3_add    = 3'b000;      // add, sub, addi
    localparam logic [2:0] f3_slt    = 3'b010;
    localparam logic [2:0] f3_sltu   = 3'b011;
    localparam logic [2:0] f3_xor    = 3'b100;
    localparam logic [2:0] f3_or     = 3'b110;
    localparam logic [2:0] f3_and    = 3'b111;

    // multiply group, only with f7_muldiv
    localparam logic [2:0] f3_mul    = 3'b000;
    localparam logic [2:0] f3_mulh   = 3'b001;
    localparam logic [2:0] f3_mulhsu = 3'b010;
    localparam logic [2:0] f3_mulhu  = 3'b011;

    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_sub    = 7'b0100000;  // only paired with f3_add
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    // ============================================================
    // instruction formats
    // ============================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;       // sign bit is imm[11]
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one word, read as either format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    // ============================================================
    // internal alu operation encoding
    // ============================================================
    localparam int alu_op_w = 4;    // eleven ops fit in four bits

    // carried from decode into the execute register
    typedef enum logic [alu_op_w-1:0] {
        alu_add    = 4'd0,      // also the fallback for unknown opcodes
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,      // signed compare, result 0 or 1
        alu_sltu   = 4'd6,      // unsigned compare
        alu_mul    = 4'd7,      // low word of the product
        alu_mulh   = 4'd8,      // high word, signed x signed
        alu_mulhsu = 4'd9,      // high word, signed x unsigned
        alu_mulhu  = 4'd10      // high word, unsigned x unsigned
    } alu_op_e;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic               clk,
    input  logic               reset,
    // two combinational read ports
    input  isa_pkg::reg_addr_t rs1,
    input  isa_pkg::reg_addr_t rs2,
    output isa_pkg::word_t     rs1_data,
    output isa_pkg::word_t     rs2_data,
    // one synchronous write port
    input  logic               we,
    input  isa_pkg::reg_addr_t wd_addr,
    input  isa_pkg::word_t     wd_data
);

    import isa_pkg::*;

    word_t regs [1:31];     // x0 has no storage

    // ============================================================
    // write port
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;      // model starts from all-zero registers
            end
        end else if (we && (wd_addr != '0)) begin   // writes to x0 are dropped
            regs[wd_addr] <= wd_data;
        end
    end

    // ============================================================
    // read ports
    // ============================================================
    // no bypass here, decode picks up same-cycle writes itself
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/result_stage.sv ====
`timescale 1ns/100ps

module result_stage (
    input  logic               clk,
    input  logic               reset,
    // from execute
    input  logic               alu_valid,
    input  isa_pkg::reg_addr_t alu_rd,
    input  isa_pkg::word_t     alu_result,
    // result port
    input  logic               result_ready,
    output logic               result_valid,
    output isa_pkg::reg_addr_t result_rd,       // also the regfile write address
    output isa_pkg::word_t     result_data,     // also the regfile write data
    // pipeline control
    output logic               advance,
    output logic               fwd_en,
    output logic               wb_en
);

    // ============================================================
    // result register
    // ============================================================
    // holds steady while a beat waits for result_ready
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result_rd    <= '0;
            result_data  <= '0;
        end else if (advance) begin
            result_valid <= alu_valid;
            result_rd    <= alu_rd;
            result_data  <= alu_result;
        end
    end

    // empty or retiring this edge -> every stage may move
    assign advance = !result_valid || result_ready;

    // forward only real writes, x0 is never a source of new data
    assign fwd_en = result_valid && (result_rd != '0);
    assign wb_en  = fwd_en && result_ready;     // write exactly once, on retirement

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
    input  logic               clk,
    input  logic               reset,
    // instruction port
    input  logic               instr_valid,
    input  isa_pkg::instr_u    instr,
    output logic               instr_ready,
    // result port, one beat per retired instruction
    output logic               result_valid,
    output isa_pkg::reg_addr_t result_rd,
    output isa_pkg::word_t     result_data,
    input  logic               result_ready
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic      advance;         // all stage registers move together
    logic      fwd_en;          // result register may feed execute
    logic      wb_en;           // result retires and writes the regfile

    // decode -> execute
    logic      ex_valid;
    alu_op_e   ex_op;
    logic      ex_use_imm;
    word_t     ex_imm;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    reg_addr_t ex_rd;

    // execute -> result
    logic      alu_valid;
    reg_addr_t alu_rd;
    word_t     alu_result;

    assign instr_ready = advance;   // accept only when the pipe can move

    decode_stage decode_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .advance     (advance),
        .wb_en       (wb_en),
        .wb_rd       (result_rd),       // result register is the write port
        .wb_data     (result_data),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_use_imm  (ex_use_imm),
        .ex_imm      (ex_imm),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_rd       (ex_rd)
    );

    execute_stage execute_i (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_use_imm  (ex_use_imm),
        .ex_imm      (ex_imm),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_rd       (ex_rd),
        .fwd_en      (fwd_en),
        .fwd_rd      (result_rd),
        .fwd_data    (result_data),
        .alu_valid   (alu_valid),
        .alu_rd      (alu_rd),
        .alu_result  (alu_result)
    );

    result_stage result_i (
        .clk          (clk),
        .reset        (reset),
        .alu_valid    (alu_valid),
        .alu_rd       (alu_rd),
        .alu_result   (alu_result),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .advance      (advance),
        .fwd_en       (fwd_en),
        .wb_en        (wb_en)
    );

endmodule

// ==== rv_core.f ====
+incdir+test
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rv_core.sv
test/rv_core_tb.sv

// ==== test/rv_core_model.svh ====
`ifndef rv_core_model_svh
`define rv_core_model_svh

// ============================================================
// architectural state, follows the core in acceptance order
// ============================================================
word_t model_regs [0:31];   // entry 0 is never written

function automatic void model_clear();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;     // core resets its registers to zero too
    end
endfunction

// instruction encoders
function automatic instr_u encode_r(input logic [6:0] funct7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] funct3,
                                    input reg_addr_t rd);
    instr_u ins;
    ins.r_fmt = '{funct7: funct7, rs2: rs2, rs1: rs1, funct3: funct3, rd: rd, opcode: op_reg};
    return ins;
endfunction

function automatic instr_u encode_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] funct3, input reg_addr_t rd);
    instr_u ins;
    ins.i_fmt = '{imm: imm, rs1: rs1, funct3: funct3, rd: rd, opcode: op_imm};
    return ins;
endfunction

// ============================================================
// alu, products taken modulo 2^64 on extended operands
// ============================================================
function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    logic [63:0] a_sx;
    logic [63:0] a_zx;
    logic [63:0] b_sx;
    logic [63:0] b_zx;
    word_t       res;
    a_sx = {{32{a[31]}}, a};
    a_zx = {32'h0, a};
    b_sx = {{32{b[31]}}, b};
    b_zx = {32'h0, b};
    case (op)
        alu_add:    res = a + b;
        alu_sub:    res = a - b;
        alu_and:    res = a & b;
        alu_or:     res = a | b;
        alu_xor:    res = a ^ b;
        alu_slt:    res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0; // bias trick
        alu_sltu:   res = (a < b) ? 32'd1 : 32'd0;
        alu_mul:    res = 32'(a_zx * b_zx);
        alu_mulh:   res = 32'((a_sx * b_sx) >> 32);
        alu_mulhsu: res = 32'((a_sx * b_zx) >> 32);
        alu_mulhu:  res = 32'((a_zx * b_zx) >> 32);
        default:    res = '0;
    endcase
    return res;
endfunction

// executes one instruction on the model state, returns the expected beat
function automatic void model_step(input instr_u ins, output reg_addr_t rd, output word_t data);
    alu_op_e op;
    logic    known;
    word_t   a;
    word_t   b;
    op    = alu_add;
    known = 1'b1;
    a     = model_regs[ins.r_fmt.rs1];
    b     = model_regs[ins.r_fmt.rs2];
    if (ins.r_fmt.opcode == op_reg) begin
        case ({ins.r_fmt.funct7, ins.r_fmt.funct3})
            {f7_base, f3_add}:      op = alu_add;
            {f7_sub, f3_add}:       op = alu_sub;
            {f7_base, f3_and}:      op = alu_and;
            {f7_base, f3_or}:       op = alu_or;
            {f7_base, f3_xor}:      op = alu_xor;
            {f7_base, f3_slt}:      op = alu_slt;
            {f7_base, f3_sltu}:     op = alu_sltu;
            {f7_muldiv, f3_mul}:    op = alu_mul;
            {f7_muldiv, f3_mulh}:   op = alu_mulh;
            {f7_muldiv, f3_mulhsu}: op = alu_mulhsu;
            {f7_muldiv, f3_mulhu}:  op = alu_mulhu;
            default:                known = 1'b0;
        endcase
    end else if (ins.i_fmt.opcode == op_imm) begin
        b = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};  // sign-extended immediate
        case (ins.i_fmt.funct3)
            f3_add:  op = alu_add;
            f3_and:  op = alu_and;
            f3_or:   op = alu_or;
            f3_xor:  op = alu_xor;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            default: known = 1'b0;
        endcase
    end else begin
        known = 1'b0;
    end
    rd   = ins.r_fmt.rd;
    data = known ? alu_model(op, a, b) : '0;   // unknown ops retire zero
    if (rd != '0) begin
        model_regs[rd] = data;                  // x0 stays zero
    end
endfunction

`endif

// ==== test/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    `include "rv_core_model.svh"

    localparam int num_instr   = 2000;
    localparam int first_phase = 200;      // result_ready held high up to here
    localparam int clk_period  = 4;
    localparam int rand_seed   = 5;
    localparam int watchdog_ns = num_instr * 20 * clk_period;

    // funct7/funct3 pairs of the r-type ops, then funct3 of the i-type ops
    localparam logic [9:0] r_ops [0:10] = '{
        {f7_base, f3_add}, {f7_sub, f3_add}, {f7_base, f3_and}, {f7_base, f3_or},
        {f7_base, f3_xor}, {f7_base, f3_slt}, {f7_base, f3_sltu}, {f7_muldiv, f3_mul},
        {f7_muldiv, f3_mulh}, {f7_muldiv, f3_mulhsu}, {f7_muldiv, f3_mulhu}};
    localparam logic [2:0] i_ops [0:5] = '{f3_add, f3_and, f3_or, f3_xor, f3_slt, f3_sltu};

    logic      clk;
    logic      reset;
    logic      instr_valid;
    instr_u    instr;
    logic      instr_ready;
    logic      result_valid;
    reg_addr_t result_rd;
    word_t     result_data;
    logic      result_ready;

    reg_addr_t exp_rd_q[$];     // scoreboard, acceptance order
    word_t     exp_data_q[$];
    int        accept_cyc_q[$];
    int        cyc;
    int        n_gen;           // beats put on the port
    int        n_accepted;
    int        n_retired;
    logic      held_valid;      // previous edge saw a waiting beat
    reg_addr_t held_rd;
    word_t     held_data;

    rv_core dut_i (.*);

    // ============================================================
    // failure reporting and compare tasks
    // ============================================================
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH at %0t: %s got x%0d expected x%0d",
                                   $time, name, got, exp));
        end
    endtask

    task automatic compare_data(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                                   $time, name, got, exp));
        end
    endtask

    // legal random op, registers only x0..x5 so hazards are frequent
    function automatic instr_u random_instr();
        int unsigned pick;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        pick = $urandom_range(16);
        rd   = reg_addr_t'($urandom_range(5));
        rs1  = reg_addr_t'($urandom_range(5));
        rs2  = reg_addr_t'($urandom_range(5));
        imm  = 12'($urandom);                   // half of them negative
        if (pick < 11) begin
            return encode_r(r_ops[pick][9:3], rs2, rs1, r_ops[pick][2:0], rd);
        end
        return encode_i(imm, rs1, i_ops[pick-11], rd);
    endfunction

    // ============================================================
    // clock and watchdog
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        report_error($sformatf("run timed out after %0d ns with %0d of %0d results seen",
                               watchdog_ns, n_retired, num_instr));
    end

    // ============================================================
    // monitor, samples pre-edge values at every rising edge
    // ============================================================
    always @(posedge clk) begin
        if (!reset) begin
            cyc++;
            if (held_valid) begin   // waiting beat must not move
                if (!result_valid) report_error("result_valid dropped before the beat retired");
                compare_rd("result_rd", result_rd, held_rd);
                compare_data("result_data", result_data, held_data);
            end
            if (result_valid && !result_ready && instr_ready) begin
                report_error("instr_ready high while a result beat waits");
            end
            if (result_valid && result_ready) begin     // retire before accept
                if (exp_rd_q.size() == 0) report_error("result beat with no instruction in flight");
                compare_rd("result_rd", result_rd, exp_rd_q.pop_front());
                compare_data("result_data", result_data, exp_data_q.pop_front());
                if ((n_retired < first_phase) && (cyc - accept_cyc_q[0] != 3)) begin
                    report_error($sformatf("instruction %0d took %0d cycles, expected 3",
                                           n_retired, cyc - accept_cyc_q[0]));
                end
                void'(accept_cyc_q.pop_front());
                n_retired++;
            end
            if (instr_valid && instr_ready) begin       // model runs at acceptance
                reg_addr_t e_rd;
                word_t     e_data;
                model_step(instr, e_rd, e_data);
                exp_rd_q.push_back(e_rd);
                exp_data_q.push_back(e_data);
                accept_cyc_q.push_back(cyc);
                n_accepted++;
            end
            held_valid = result_valid && !result_ready;
            held_rd    = result_rd;
            held_data  = result_data;
        end
    end

    // ============================================================
    // stimulus, driven on falling edges
    // ============================================================
    initial begin
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        result_ready = 1'b0;
        cyc          = 0;
        n_gen        = 0;
        n_accepted   = 0;
        n_retired    = 0;
        held_valid   = 1'b0;
        void'($urandom(rand_seed));     // one seed for the whole run
        model_clear();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        if (result_valid !== 1'b0) report_error("result_valid not low after reset");
        if (instr_ready !== 1'b1) report_error("instr_ready not high after reset");

        while (n_retired < num_instr) begin
            @(negedge clk);
            // 40% back-pressure once the latency phase is over
            result_ready = (n_retired < first_phase) ? 1'b1 : ($urandom_range(99) >= 40);
            if (!(instr_valid && (n_accepted < n_gen))) begin   // nothing waiting on the port
                if ((n_gen < num_instr) && ($urandom_range(9) != 0)) begin
                    instr       = random_instr();
                    instr_valid = 1'b1;
                    n_gen++;
                end else begin
                    instr_valid = 1'b0;                         // bubble
                end
            end
        end

        repeat (8) @(negedge clk);      // catch any stray extra beat
        if ((exp_rd_q.size() == 0) && (n_retired == num_instr)) begin
            $display("Test passed");
            $finish;
        end else begin
            report_error($sformatf("%0d results never came out", exp_rd_q.size()));
        end
    end

endmodule
